//--- design/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

    localparam int PIXEL_WIDTH = 12;
    localparam int MAX_LINE    = 64;   // also the depth of each line buffer
    localparam int MIN_LINE    = 5;
    localparam int WIN_SIZE    = 5;
    localparam int TAP_COUNT   = WIN_SIZE * WIN_SIZE;

    // address bits needed to index one line buffer
    localparam int LB_ADDR_BITS = $clog2(MAX_LINE);

    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    // wide enough to hold MAX_LINE itself
    typedef logic [6:0] line_idx_t;

    typedef logic [4:0] tap_sel_t;

    // column 0 is the oldest pixel of the row
    typedef pixel_t [WIN_SIZE-1:0] win_row_t;

    // row 0 is the oldest line, so the newest pixel sits at [4][4]
    typedef win_row_t [WIN_SIZE-1:0] window_t;

    typedef struct packed {
        logic   valid;
        pixel_t data;
    } pix_stream_t;

endpackage

`default_nettype wire

//--- design/axil_pkg.sv
`default_nettype none

package axil_pkg;

    localparam int AXIL_ADDR_BITS = 4;
    localparam int AXIL_DATA_BITS = 32;

    localparam logic [AXIL_ADDR_BITS-1:0] ADDR_TAP_SEL = 4'h0;
    localparam logic [AXIL_ADDR_BITS-1:0] ADDR_WIDTH   = 4'h4;
    localparam logic [AXIL_ADDR_BITS-1:0] ADDR_COUNT   = 4'h8;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axil_resp_e;

    typedef enum logic {
        W_IDLE,
        W_RESP
    } axil_wstate_e;

    typedef enum logic {
        R_IDLE,
        R_DATA
    } axil_rstate_e;

    typedef struct packed {
        logic                      awvalid;
        logic [AXIL_ADDR_BITS-1:0] awaddr;
        logic                      wvalid;
        logic [AXIL_DATA_BITS-1:0] wdata;
        logic                      bready;
        logic                      arvalid;
        logic [AXIL_ADDR_BITS-1:0] araddr;
        logic                      rready;
    } axil_req_t;

    typedef struct packed {
        logic                      awready;
        logic                      wready;
        logic                      bvalid;
        axil_resp_e                bresp;
        logic                      arready;
        logic                      rvalid;
        logic [AXIL_DATA_BITS-1:0] rdata;
        axil_resp_e                rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

//--- design/axil_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module axil_cfg_regs
    import pixel_pkg::*;
    import axil_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    input  logic      pixel_accept,
    output tap_sel_t  tap_sel,
    output line_idx_t line_width,
    output logic      clear
);

    axil_wstate_e              wstate;
    axil_rstate_e              rstate;
    axil_resp_e                bresp;
    axil_resp_e                rresp;
    logic [AXIL_DATA_BITS-1:0] rdata;
    logic [AXIL_DATA_BITS-1:0] pixel_count;
    logic                      wr_fire;
    logic                      rd_fire;

    // address and data are taken together, never one without the other
    assign wr_fire = (wstate == W_IDLE) && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = (rstate == R_IDLE) && axil_req.arvalid;

    always_comb begin
        axil_rsp.awready = wr_fire;
        axil_rsp.wready  = wr_fire;
        axil_rsp.bvalid  = (wstate == W_RESP);
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = rd_fire;
        axil_rsp.rvalid  = (rstate == R_DATA);
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wstate     <= W_IDLE;
            bresp      <= OKAY;
            tap_sel    <= tap_sel_t'(TAP_COUNT - 1);   // newest pixel, a plain pass-through
            line_width <= line_idx_t'(MAX_LINE);
            clear      <= 1'b0;
        end else begin
            clear <= 1'b0;
            case (wstate)
                W_IDLE: begin
                    if (wr_fire) begin
                        wstate <= W_RESP;
                        bresp  <= SLVERR;
                        case (axil_req.awaddr)
                            ADDR_TAP_SEL: begin
                                tap_sel <= axil_req.wdata[4:0];
                                bresp   <= OKAY;
                            end
                            ADDR_WIDTH: begin
                                if (axil_req.wdata >= MIN_LINE && axil_req.wdata <= MAX_LINE) begin
                                    line_width <= axil_req.wdata[6:0];
                                    clear      <= 1'b1;   // restart the window at the new width
                                    bresp      <= OKAY;
                                end
                            end
                            default: ;   // count is read only
                        endcase
                    end
                end
                W_RESP: if (axil_req.bready) wstate <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rstate <= R_IDLE;
            rresp  <= OKAY;
        end else begin
            case (rstate)
                R_IDLE: begin
                    if (rd_fire) begin
                        rstate <= R_DATA;
                        rresp  <= OKAY;
                        case (axil_req.araddr)
                            ADDR_TAP_SEL: rdata <= AXIL_DATA_BITS'(tap_sel);
                            ADDR_WIDTH:   rdata <= AXIL_DATA_BITS'(line_width);
                            ADDR_COUNT:   rdata <= pixel_count;
                            default: begin
                                rdata <= '0;
                                rresp <= SLVERR;
                            end
                        endcase
                    end
                end
                R_DATA: if (axil_req.rready) rstate <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) pixel_count <= '0;
        else if (pixel_accept) pixel_count <= pixel_count + 1'b1;
    end

    bvalid_held: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);

endmodule

`default_nettype wire

//--- design/line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module line_buffer
    import pixel_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clear,
    input  logic      shift,
    input  line_idx_t line_width,
    input  pixel_t    din,
    output pixel_t    dout
);

    pixel_t    mem [MAX_LINE];
    line_idx_t ptr;
    logic      filled;   // set once the pointer has gone all the way round

    // the entry under the pointer is the pixel written one line ago
    assign dout = filled ? mem[ptr[LB_ADDR_BITS-1:0]] : '0;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            ptr    <= '0;
            filled <= 1'b0;
        end else if (shift) begin
            if (ptr >= line_width - 1'b1) begin
                ptr    <= '0;
                filled <= 1'b1;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift) mem[ptr[LB_ADDR_BITS-1:0]] <= din;   // read old, write new in one slot
    end

    // a width write moves line_width one cycle before clear brings the pointer back
    ptr_in_line: assert property (@(posedge clk) disable iff (reset || clear)
        ptr < line_width);

endmodule

`default_nettype wire

//--- design/window_5x5.sv
`timescale 1ns/10ps
`default_nettype none

module window_5x5
    import pixel_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clear,
    input  logic      shift,
    input  line_idx_t line_width,
    input  pixel_t    din,
    output window_t   window
);

    pixel_t row_in [WIN_SIZE];   // pixel entering each window row

    assign row_in[WIN_SIZE-1] = din;

    // each line buffer delays the feed of the row below by one line
    for (genvar r = 0; r < WIN_SIZE - 1; r++) begin : g_lines
        line_buffer i_line_buffer (
            .clk        (clk),
            .reset      (reset),
            .clear      (clear),
            .shift      (shift),
            .line_width (line_width),
            .din        (row_in[r+1]),
            .dout       (row_in[r])
        );
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            window <= '0;
        end else if (shift) begin
            for (int r = 0; r < WIN_SIZE; r++) begin
                // new pixel lands in column 4 and the rest move one column older
                window[r] <= {row_in[r], window[r][WIN_SIZE-1:1]};
            end
        end
    end

endmodule

`default_nettype wire

//--- design/tap_mux25.sv
`timescale 1ns/10ps
`default_nettype none

module tap_mux25
    import pixel_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  window_t     window,
    input  tap_sel_t    tap_sel,
    input  logic        in_valid,
    output logic        in_ready,
    output pix_stream_t out_stream,
    input  logic        out_ready
);

    logic     accept;
    logic     load;
    logic     pend;      // the window holds a pixel that has not reached the output yet
    logic     out_valid;
    pixel_t   out_data;
    pixel_t   sel_pix;
    tap_sel_t tap_q;     // tap in force when the pending pixel was accepted

    assign in_ready = out_ready || !out_valid;
    assign accept   = in_valid && in_ready;
    assign load     = pend && in_ready;   // a new accept always coincides with a load

    always_comb begin
        sel_pix = '0;   // index 25 and above stays zero
        for (int ty = 0; ty < WIN_SIZE; ty++) begin
            for (int tx = 0; tx < WIN_SIZE; tx++) begin
                if (tap_q == tap_sel_t'(ty * WIN_SIZE + tx)) sel_pix = window[ty][tx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            pend <= accept || (pend && !load);
            if (load) out_valid <= 1'b1;
            else if (out_ready) out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) tap_q <= tap_sel;
        if (load) out_data <= sel_pix;
    end

    assign out_stream = '{valid: out_valid, data: out_data};

    out_data_held: assert property (@(posedge clk) disable iff (reset)
        out_stream.valid && !out_ready |=> out_stream.valid && $stable(out_stream.data));

endmodule

`default_nettype wire

//--- design/window_tap_top.sv
`timescale 1ns/10ps
`default_nettype none

module window_tap_top
    import pixel_pkg::*;
    import axil_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  axil_req_t   axil_req,
    output axil_rsp_t   axil_rsp,
    input  pix_stream_t in_stream,
    output logic        in_ready,
    output pix_stream_t out_stream,
    input  logic        out_ready
);

    logic      pixel_accept;
    logic      clear;
    tap_sel_t  tap_sel;
    line_idx_t line_width;
    window_t   window;

    assign pixel_accept = in_stream.valid && in_ready;

    axil_cfg_regs i_axil_cfg_regs (
        .clk          (clk),
        .reset        (reset),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .pixel_accept (pixel_accept),
        .tap_sel      (tap_sel),
        .line_width   (line_width),
        .clear        (clear)
    );

    window_5x5 i_window_5x5 (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .shift      (pixel_accept),
        .line_width (line_width),
        .din        (in_stream.data),
        .window     (window)
    );

    // the mux reads the window a cycle after the shift so the new pixel is included
    tap_mux25 i_tap_mux25 (
        .clk        (clk),
        .reset      (reset),
        .window     (window),
        .tap_sel    (tap_sel),
        .in_valid   (in_stream.valid),
        .in_ready   (in_ready),
        .out_stream (out_stream),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/tb_window_tap.sv
`timescale 1ns/10ps
`default_nettype none

module tb_window_tap
    import pixel_pkg::*;
    import axil_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20000;   // all tests together take about 2000 cycles
    localparam int RAND_SEED      = 32'h7c14;

    logic        clk;
    logic        reset;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    pix_stream_t in_stream;
    logic        in_ready;
    pix_stream_t out_stream;
    logic        out_ready;

    pixel_t hist[$];          // pixels accepted since the last clear
    int     out_count;        // outputs seen since the last clear
    int     cur_tap;
    int     cur_width;
    int     seed_val;
    int     cycle_count = 0;

    tb_clock i_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    window_tap_top i_window_tap_top (
        .clk        (clk),
        .reset      (reset),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .in_stream  (in_stream),
        .in_ready   (in_ready),
        .out_stream (out_stream),
        .out_ready  (out_ready)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT stopped answering within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // the pixel accepted (4-ty)*W + (4-tx) places earlier, zero before the first one
    function automatic pixel_t expected_pixel(input int n);
        int src;
        if (cur_tap >= TAP_COUNT) return '0;
        src = n - ((4 - cur_tap / WIN_SIZE) * cur_width + (4 - cur_tap % WIN_SIZE));
        if (src < 0) return '0;
        return hist[src];
    endfunction

    task automatic write_reg(input logic [3:0] addr, input int data, input axil_resp_e exp_resp);
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.bready  <= 1'b1;
        @(negedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready)) @(negedge clk);
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.bvalid) @(negedge clk);
        check_value("bresp", 32'(axil_rsp.bresp), 32'(exp_resp));
        @(posedge clk);
        axil_req.bready <= 1'b0;
        if (addr == ADDR_TAP_SEL) cur_tap = data & 31;
        if (addr == ADDR_WIDTH && data >= MIN_LINE && data <= MAX_LINE) begin
            cur_width = data;   // a legal width restarts the window
            hist.delete();
            out_count = 0;
        end
    endtask

    task automatic read_reg(input logic [3:0] addr, input int exp_data, input axil_resp_e exp_resp);
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.rvalid) @(negedge clk);
        check_value("rdata", axil_rsp.rdata, exp_data);
        check_value("rresp", 32'(axil_rsp.rresp), 32'(exp_resp));
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    // drives count random pixels and checks every output until all of them came back
    task automatic stream_pixels(input int count, input bit toggle_ready);
        int   sent;
        int   got;
        logic take_in;
        sent = 0;
        got = 0;
        take_in = 1'b0;
        while (got < count) begin
            @(posedge clk);
            if (take_in) sent++;
            if (!in_stream.valid || take_in) begin
                if (sent < count) in_stream <= '{valid: 1'b1, data: pixel_t'($urandom)};
                else in_stream <= '0;
            end
            out_ready <= toggle_ready ? 1'($urandom_range(1, 0)) : 1'b1;
            @(negedge clk);
            take_in = in_stream.valid && in_ready;   // handshake at the coming edge
            if (take_in) hist.push_back(in_stream.data);
            if (out_stream.valid && out_ready) begin
                check_value("out_stream.data", 32'(out_stream.data),
                            32'(expected_pixel(out_count)));
                out_count++;
                got++;
            end
        end
    endtask

    task automatic reset_defaults();
        check_value("out_stream.valid", 32'(out_stream.valid), 32'd0);
        read_reg(ADDR_TAP_SEL, 24, OKAY);
        read_reg(ADDR_WIDTH, 64, OKAY);
        read_reg(ADDR_COUNT, 0, OKAY);
    endtask

    task automatic corner_taps();
        write_reg(ADDR_WIDTH, 8, OKAY);
        write_reg(ADDR_TAP_SEL, 24, OKAY);
        stream_pixels(40, 1'b0);
        write_reg(ADDR_TAP_SEL, 0, OKAY);
        write_reg(ADDR_WIDTH, 8, OKAY);   // restart so the first 36 outputs are zero fill
        stream_pixels(80, 1'b0);
    endtask

    task automatic inner_taps();
        int taps[4] = '{12, 4, 20, 27};
        foreach (taps[i]) begin
            write_reg(ADDR_TAP_SEL, taps[i], OKAY);
            write_reg(ADDR_WIDTH, 5, OKAY);
            stream_pixels(45, 1'b0);
        end
    endtask

    task automatic ready_toggling();
        write_reg(ADDR_WIDTH, 8, OKAY);
        write_reg(ADDR_TAP_SEL, 7, OKAY);
        stream_pixels(200, 1'b1);
        read_reg(ADDR_COUNT, hist.size(), OKAY);
    endtask

    task automatic bad_accesses();
        write_reg(ADDR_WIDTH, 3, SLVERR);
        write_reg(ADDR_WIDTH, 65, SLVERR);
        write_reg(ADDR_COUNT, 5, SLVERR);
        write_reg(4'hC, 1, SLVERR);
        read_reg(4'hC, 0, SLVERR);
        read_reg(ADDR_WIDTH, cur_width, OKAY);
    endtask

    task automatic width_restart();
        write_reg(ADDR_TAP_SEL, 0, OKAY);
        stream_pixels(30, 1'b0);
        read_reg(ADDR_COUNT, hist.size(), OKAY);
        write_reg(ADDR_WIDTH, 6, OKAY);
        read_reg(ADDR_COUNT, 0, OKAY);
        stream_pixels(40, 1'b0);   // 28 zero-fill outputs come first at width 6
    endtask

    initial begin
        seed_val  = $urandom(RAND_SEED);
        axil_req  = '0;
        in_stream = '0;
        out_ready = 1'b1;
        out_count = 0;
        cur_tap   = TAP_COUNT - 1;
        cur_width = MAX_LINE;
        @(posedge clk);
        while (reset) @(posedge clk);
        reset_defaults();
        corner_taps();
        inner_taps();
        ready_toggling();
        bad_accesses();
        width_restart();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
design/pixel_pkg.sv
design/axil_pkg.sv
design/axil_cfg_regs.sv
design/line_buffer.sv
design/window_5x5.sv
design/tap_mux25.sv
design/window_tap_top.sv
testbench/tb_clock.sv
testbench/tb_window_tap.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f src.f --top-module tb_window_tap -o sim_tb_window_tap

./obj_dir/sim_tb_window_tap 2>&1 | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
